/* source/lmem_params.svh */
// Local memory size parameters
`ifndef LMEM_PARAMS_SVH
`define LMEM_PARAMS_SVH

// Word width in bits
`define LMEM_DATAW 32

// Byte lanes per word
`define LMEM_BYTES 4

// Bank depth in words and the matching word address width
`define LMEM_WORDS 64
`define LMEM_ADDRW 6

// Client tag width
`define LMEM_TAGW 4

// Request queue depth in entries
`define LMEM_QDEPTH 4

`endif

/* source/lmem_pkg.sv */
// Local memory types
`default_nettype none

`include "lmem_params.svh"

package lmem_pkg;

    typedef enum logic {
        LMEM_READ  = 1'b0,
        LMEM_WRITE = 1'b1
    } lmem_op_e;

    // One client request, 47 bits
    typedef struct packed {
        lmem_op_e                op;
        logic [`LMEM_ADDRW-1:0] addr;
        logic [`LMEM_BYTES-1:0] byteen;
        logic [`LMEM_DATAW-1:0] data;
        logic [`LMEM_TAGW-1:0]  tag;
    } lmem_req_t;

    // Read response, 36 bits
    typedef struct packed {
        logic [`LMEM_DATAW-1:0] data;
        logic [`LMEM_TAGW-1:0]  tag;
    } lmem_rsp_t;

endpackage

`default_nettype wire

/* source/dp_ram.sv */
// Dual-port RAM with byte write mask
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
    parameter int DATAW   = 1,
    parameter int SIZE    = 2,
    parameter int WRENW   = 1,
    parameter int OUT_REG = 0
) (
    input  wire logic                     clk,
    input  wire logic                     read,
    input  wire logic                     write,
    input  wire logic [WRENW-1:0]         wren,
    input  wire logic [$clog2(SIZE)-1:0]  waddr,
    input  wire logic [DATAW-1:0]         wdata,
    input  wire logic [$clog2(SIZE)-1:0]  raddr,
    output logic      [DATAW-1:0]         rdata
);

    // Width of one independently writable slice
    localparam int WSELW = DATAW / WRENW;

    logic [WRENW-1:0][WSELW-1:0] ram [SIZE];

    // Contents start at zero, reset never touches them
    initial begin
        for (int i = 0; i < SIZE; i++) begin
            ram[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < WRENW; i++) begin
                if (wren[i]) begin
                    ram[waddr][i] <= wdata[i*WSELW +: WSELW];
                end
            end
        end
    end

    if (OUT_REG != 0) begin : g_out_reg
        logic [DATAW-1:0] rdata_r;

        // Output holds its value until the next read strobe
        always_ff @(posedge clk) begin
            if (read) begin
                rdata_r <= ram[raddr];
            end
        end

        assign rdata = rdata_r;
    end else begin : g_out_comb
        // Asynchronous read, the strobe has no effect here
        assign rdata = ram[raddr];
    end

endmodule

`default_nettype wire

/* source/req_fifo.sv */
// Request queue
`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module req_fifo #(
    parameter int DEPTH = `LMEM_QDEPTH
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                push,
    input  wire lmem_pkg::lmem_req_t din,
    input  wire logic                pop,
    output lmem_pkg::lmem_req_t      head,
    output logic                     empty,
    output logic                     full
);

    localparam int PTRW = $clog2(DEPTH);
    localparam int REQW = $bits(lmem_pkg::lmem_req_t);

    logic [PTRW-1:0] wr_ptr;
    logic [PTRW-1:0] rd_ptr;
    logic [PTRW:0]   count;
    logic            do_push;
    logic            do_pop;

    // A push into a full queue is dropped, a pop from an empty one is ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == DEPTH[PTRW:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry is visible combinationally at the read pointer
    dp_ram #(
        .DATAW   (REQW),
        .SIZE    (DEPTH),
        .WRENW   (1),
        .OUT_REG (0)
    ) u_store (
        .clk   (clk),
        .read  (do_pop),
        .write (do_push),
        .wren  (1'b1),
        .waddr (wr_ptr),
        .wdata (din),
        .raddr (rd_ptr),
        .rdata (head)
    );

endmodule

`default_nettype wire

/* source/lmem_bank.sv */
// Local memory bank
`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_bank (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                hold,
    input  wire lmem_pkg::lmem_req_t head,
    input  wire logic                empty,
    output logic                     pop,
    output logic                     rsp_valid,
    output lmem_pkg::lmem_rsp_t      rsp
);

    logic                   wr_en;
    logic                   rd_en;
    logic                   rd_pend;
    logic [`LMEM_ADDRW-1:0] rd_addr;
    logic [`LMEM_TAGW-1:0]  rd_tag;
    logic [`LMEM_TAGW-1:0]  rsp_tag;
    logic [`LMEM_DATAW-1:0] rdata;

    assign pop   = !empty && !hold;
    assign wr_en = pop && (head.op == lmem_pkg::LMEM_WRITE);
    assign rd_en = pop && (head.op == lmem_pkg::LMEM_READ);

    // A popped read is staged for one cycle before the RAM read,
    // so a write popped right after it cannot disturb its data
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rd_pend   <= rd_en;
            rsp_valid <= rd_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_addr <= head.addr;
            rd_tag  <= head.tag;
        end
        if (rd_pend) begin
            rsp_tag <= rd_tag;
        end
    end

    dp_ram #(
        .DATAW   (`LMEM_DATAW),
        .SIZE    (`LMEM_WORDS),
        .WRENW   (`LMEM_BYTES),
        .OUT_REG (1)
    ) u_mem (
        .clk   (clk),
        .read  (rd_pend),
        .write (wr_en),
        .wren  (head.byteen),
        .waddr (head.addr),
        .wdata (head.data),
        .raddr (rd_addr),
        .rdata (rdata)
    );

    assign rsp.data = rdata;
    assign rsp.tag  = rsp_tag;

endmodule

`default_nettype wire

/* source/lmem_top.sv */
// Local memory unit top
`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module lmem_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req_push,
    input  wire lmem_pkg::lmem_req_t req,
    input  wire logic                hold,
    output logic                     full,
    output logic                     rsp_valid,
    output lmem_pkg::lmem_rsp_t      rsp
);

    lmem_pkg::lmem_req_t head;
    logic                empty;
    logic                pop;

    req_fifo #(
        .DEPTH (`LMEM_QDEPTH)
    ) u_queue (
        .clk   (clk),
        .rst   (rst),
        .push  (req_push),
        .din   (req),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (full)
    );

    lmem_bank u_bank (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/lmem_chk.sv */
// Local memory protocol checks
`timescale 1ns/1ps
`default_nettype none

module lmem_chk (
    input wire logic clk,
    input wire logic rst,
    input wire logic req_push,
    input wire logic full,
    input wire logic empty,
    input wire logic rsp_valid
);

    // The client has to respect the full level
    push_not_full: assert property (
        @(posedge clk) disable iff (rst) full |-> !req_push
    ) else $error("request pushed while the queue is full");

    // Synchronous reset clears the response strobe
    rsp_quiet_in_reset: assert property (
        @(posedge clk) rst |=> !rsp_valid
    ) else $error("response strobe high after a reset cycle");

    // One push per cycle, so an empty queue cannot be full a cycle later
    no_full_after_empty: assert property (
        @(posedge clk) disable iff (rst) empty |=> !full
    ) else $error("queue went from empty to full in one cycle");

endmodule

bind lmem_top lmem_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .req_push  (req_push),
    .full      (full),
    .empty     (empty),
    .rsp_valid (rsp_valid)
);

`default_nettype wire

/* testbench/tb_lmem.sv */
// Local memory unit testbench
`timescale 1ns/1ps
`default_nettype none

`include "lmem_params.svh"

module tb_lmem;

    localparam int NRAND = 40;
    localparam int BYTEW = `LMEM_DATAW / `LMEM_BYTES;

    typedef struct packed {
        logic                push;
        logic                hold;
        lmem_pkg::lmem_req_t req;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   req_push;
    logic                   hold;
    lmem_pkg::lmem_req_t    req;
    logic                   full;
    logic                   rsp_valid;
    lmem_pkg::lmem_rsp_t    rsp;

    row_t                   rows[$];
    lmem_pkg::lmem_req_t    model_q[$];
    lmem_pkg::lmem_rsp_t    exp_q[$];
    int                     exp_cyc[$];
    logic [`LMEM_DATAW-1:0] shadow [`LMEM_WORDS];
    int                     edge_n;
    int                     cycles = 0;
    int                     limit;
    int                     n_reads;
    int                     n_rsp;
    integer                 seed;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    lmem_top UUT (
        .clk       (clk),
        .rst       (rst),
        .req_push  (req_push),
        .req       (req),
        .hold      (hold),
        .full      (full),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic compare_rsp(input lmem_pkg::lmem_rsp_t got, input lmem_pkg::lmem_rsp_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error rsp: data %h tag %h, expected data %h tag %h",
                               got.data, got.tag, exp.data, exp.tag));
        end
    endtask

    task automatic compare_full(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error full: got %h, expected %h", got, exp));
        end
    endtask

    task automatic add_row(input logic push, input logic hold_lvl, input lmem_pkg::lmem_op_e op,
                           input logic [`LMEM_ADDRW-1:0] addr, input logic [`LMEM_BYTES-1:0] be,
                           input logic [`LMEM_DATAW-1:0] data, input logic [`LMEM_TAGW-1:0] tag);
        row_t r;
        r.push       = push;
        r.hold       = hold_lvl;
        r.req.op     = op;
        r.req.addr   = addr;
        r.req.byteen = be;
        r.req.data   = data;
        r.req.tag    = tag;
        rows.push_back(r);
    endtask

    task automatic add_idle(input logic hold_lvl, input int n);
        repeat (n) add_row(1'b0, hold_lvl, lmem_pkg::LMEM_READ, '0, '0, '0, '0);
    endtask

    // In-order queue model with one pop per edge while not held
    // A pushed read carries the word it should return
    task automatic model_edge(input row_t r);
        lmem_pkg::lmem_req_t ent;
        lmem_pkg::lmem_rsp_t rsp_exp;
        edge_n++;
        if (model_q.size() > 0 && !r.hold) begin
            ent = model_q.pop_front();
            if (ent.op == lmem_pkg::LMEM_READ) begin
                rsp_exp.data = ent.data;
                rsp_exp.tag  = ent.tag;
                exp_q.push_back(rsp_exp);
                exp_cyc.push_back(edge_n + 1);
            end
        end
        if (r.push) begin
            ent = r.req;
            if (ent.op == lmem_pkg::LMEM_WRITE) begin
                for (int b = 0; b < `LMEM_BYTES; b++) begin
                    if (ent.byteen[b]) begin
                        shadow[ent.addr][b*BYTEW +: BYTEW] = ent.data[b*BYTEW +: BYTEW];
                    end
                end
            end else begin
                ent.data = shadow[ent.addr];
                n_reads++;
            end
            model_q.push_back(ent);
        end
    endtask

    task automatic check_outputs();
        compare_full(full, model_q.size() == `LMEM_QDEPTH);
        if (rsp_valid && exp_q.size() == 0) begin
            fail_run("A response arrived with no read outstanding");
        end else if (rsp_valid && exp_cyc[0] != edge_n) begin
            fail_run($sformatf("A response came in cycle %0d, it was due in cycle %0d",
                               edge_n, exp_cyc[0]));
        end else if (rsp_valid) begin
            compare_rsp(rsp, exp_q.pop_front());
            void'(exp_cyc.pop_front());
        end else if (exp_q.size() > 0 && exp_cyc[0] <= edge_n) begin
            fail_run("An expected read response did not arrive");
        end
    endtask

    task automatic run_cycle(input row_t r);
        req_push = r.push;
        hold     = r.hold;
        req      = r.req;
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        model_edge(r);
        #1;
    endtask

    // Every response strobe counts, including any after the last expected one
    always @(negedge clk) begin
        if (rsp_valid === 1'b1) begin
            n_rsp++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            fail_run($sformatf("Timeout after %0d cycles", cycles));
        end
    end

    initial begin
        row_t        r;
        logic [31:0] rnd;
        req_push = 1'b0;
        hold     = 1'b0;
        req      = '0;
        seed     = 32'hb42e;
        edge_n   = 0;
        n_reads  = 0;
        n_rsp    = 0;
        for (int i = 0; i < `LMEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        // Unwritten read, full write, partial writes and their reads
        add_row(1'b1, 1'b0, lmem_pkg::LMEM_READ, 6'd5, 4'h0, 32'h0, 4'h1);
        add_idle(1'b0, 2);
        add_row(1'b1, 1'b0, lmem_pkg::LMEM_WRITE, 6'd9, 4'hf, 32'hdeadbeef, 4'h2);
        add_row(1'b1, 1'b0, lmem_pkg::LMEM_READ, 6'd9, 4'h0, 32'h0, 4'h3);
        add_row(1'b1, 1'b0, lmem_pkg::LMEM_WRITE, 6'd9, 4'h5, 32'h11223344, 4'h4);
        add_row(1'b1, 1'b0, lmem_pkg::LMEM_READ, 6'd9, 4'h0, 32'h0, 4'h5);
        add_row(1'b1, 1'b0, lmem_pkg::LMEM_WRITE, 6'd10, 4'h8, 32'ha5a5a5a5, 4'h6);
        add_row(1'b1, 1'b0, lmem_pkg::LMEM_READ, 6'd10, 4'h0, 32'h0, 4'h7);
        add_idle(1'b0, 2);
        // Fill the queue under hold, then release it
        add_row(1'b1, 1'b1, lmem_pkg::LMEM_READ, 6'd9, 4'h0, 32'h0, 4'h8);
        add_row(1'b1, 1'b1, lmem_pkg::LMEM_READ, 6'd10, 4'h0, 32'h0, 4'h9);
        add_row(1'b1, 1'b1, lmem_pkg::LMEM_READ, 6'd5, 4'h0, 32'h0, 4'ha);
        add_row(1'b1, 1'b1, lmem_pkg::LMEM_READ, 6'd3, 4'h0, 32'h0, 4'hb);
        add_idle(1'b1, 2);
        add_idle(1'b0, 4);
        limit = 2 * (rows.size() + NRAND) + 20;
        @(negedge rst);
        foreach (rows[i]) begin
            run_cycle(rows[i]);
        end
        repeat (NRAND) begin
            rnd          = $random(seed);
            r.push       = 1'b1;
            r.hold       = 1'b0;
            r.req.op     = lmem_pkg::lmem_op_e'(rnd[31]);
            r.req.addr   = {{(`LMEM_ADDRW-4){1'b0}}, rnd[3:0]};
            r.req.byteen = rnd[7:4];
            r.req.tag    = rnd[11:8];
            r.req.data   = $random(seed);
            run_cycle(r);
        end
        while (exp_q.size() > 0 || model_q.size() > 0) begin
            run_cycle('0);
        end
        // Idle tail so a late extra response still shows up in the count
        repeat (3) @(posedge clk);
        if (n_rsp != n_reads) begin
            fail_run($sformatf("Got %0d responses for %0d reads", n_rsp, n_reads));
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/lmem_pkg.sv
source/dp_ram.sv
source/req_fifo.sv
source/lmem_bank.sv
source/lmem_top.sv
testbench/tb_clock.sv
testbench/lmem_chk.sv
testbench/tb_lmem.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_lmem
FILELIST = project.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
